//--- hdl/riscv_consts.svh
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// data and address width
`define RISCV_XLEN 32
`define RISCV_REG_COUNT 32
`define RISCV_REG_BITS 5

`define RISCV_RESET_PC 32'h0000_0000
`define RISCV_INSTR_STEP 32'd4

`endif

//--- hdl/riscv_isa_pkg.sv
`include "riscv_consts.svh"

package riscv_isa_pkg;

  // major opcodes, full 7-bit field since only 32-bit encodings exist
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // encoded as funct3 of the branch opcode
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_op_e;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_size_e;

  typedef enum logic [2:0] {
    CLS_ALU, CLS_LOAD, CLS_STORE, CLS_BRANCH,
    CLS_JAL, CLS_JALR, CLS_LUI, CLS_AUIPC
  } instr_class_e;

  typedef struct packed {
    logic                       valid;
    instr_class_e               cls;
    logic                       use_imm;
    alu_op_e                    alu_op;
    branch_op_e                 branch_op;
    mem_size_e                  size;
    logic                       unsigned_load;
    logic [`RISCV_REG_BITS-1:0] rs1;
    logic [`RISCV_REG_BITS-1:0] rs2;
    logic [`RISCV_REG_BITS-1:0] rd;
    logic [`RISCV_XLEN-1:0]     imm;
  } decoded_t;

endpackage

//--- hdl/riscv_core_pkg.sv
package riscv_core_pkg;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXECUTE,
    ST_MEM_WAIT,
    ST_WRITEBACK,
    ST_TRAP
  } ctrl_state_e;

  // what the load/store unit is asked to do on the bus
  typedef enum logic [1:0] {
    LSU_FETCH,
    LSU_LOAD,
    LSU_STORE
  } lsu_kind_e;

endpackage

//--- hdl/riscv_lsu_if.sv
`include "riscv_consts.svh"

interface riscv_lsu_if;
  logic                       req;
  riscv_core_pkg::lsu_kind_e  kind;
  riscv_isa_pkg::mem_size_e   size;
  logic                       unsigned_load;
  logic [`RISCV_XLEN-1:0]     addr;
  logic [`RISCV_XLEN-1:0]     store_data;
  logic                       done;
  logic [`RISCV_XLEN-1:0]     rdata;
  logic                       misaligned;

  modport requester (
    output req, kind, size, unsigned_load, addr, store_data,
    input  done, rdata, misaligned
  );
  modport responder (
    input  req, kind, size, unsigned_load, addr, store_data,
    output done, rdata, misaligned
  );
endinterface

//--- hdl/riscv_decoder.sv
`include "riscv_consts.svh"

module riscv_decoder (
  input  logic [`RISCV_XLEN-1:0]   instr,
  output riscv_isa_pkg::decoded_t  dec
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt;
  logic [`RISCV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign alt = funct7 == 7'b0100000;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  function automatic riscv_isa_pkg::alu_op_e alu_sel(logic [2:0] f3, logic high);
    case (f3)
      3'b000:  alu_sel = high ? riscv_isa_pkg::ALU_SUB : riscv_isa_pkg::ALU_ADD;
      3'b001:  alu_sel = riscv_isa_pkg::ALU_SLL;
      3'b010:  alu_sel = riscv_isa_pkg::ALU_SLT;
      3'b011:  alu_sel = riscv_isa_pkg::ALU_SLTU;
      3'b100:  alu_sel = riscv_isa_pkg::ALU_XOR;
      3'b101:  alu_sel = high ? riscv_isa_pkg::ALU_SRA : riscv_isa_pkg::ALU_SRL;
      3'b110:  alu_sel = riscv_isa_pkg::ALU_OR;
      default: alu_sel = riscv_isa_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    dec = '0;
    dec.cls = riscv_isa_pkg::CLS_ALU;
    dec.alu_op = riscv_isa_pkg::ALU_ADD;
    dec.branch_op = riscv_isa_pkg::branch_op_e'(funct3);
    dec.size = riscv_isa_pkg::mem_size_e'(funct3[1:0]);
    dec.unsigned_load = funct3[2];
    dec.rs1 = instr[19:15];
    dec.rs2 = instr[24:20];
    dec.rd = instr[11:7];
    case (instr[6:0])
      riscv_isa_pkg::OPC_LUI, riscv_isa_pkg::OPC_AUIPC: begin
        dec.valid = 1'b1;
        dec.cls = instr[5] ? riscv_isa_pkg::CLS_LUI : riscv_isa_pkg::CLS_AUIPC;
        dec.use_imm = 1'b1;
        // rs1 field is immediate here, x0 gives a zero first operand for lui
        dec.rs1 = '0;
        dec.imm = imm_u;
      end
      riscv_isa_pkg::OPC_JAL: begin
        dec.valid = 1'b1;
        dec.cls = riscv_isa_pkg::CLS_JAL;
        dec.imm = imm_j;
      end
      riscv_isa_pkg::OPC_JALR: begin
        dec.valid = funct3 == 3'b000;
        dec.cls = riscv_isa_pkg::CLS_JALR;
        dec.use_imm = 1'b1;
        dec.imm = imm_i;
      end
      riscv_isa_pkg::OPC_BRANCH: begin
        dec.valid = funct3[2:1] != 2'b01;
        dec.cls = riscv_isa_pkg::CLS_BRANCH;
        dec.rd = '0;
        dec.imm = imm_b;
      end
      riscv_isa_pkg::OPC_LOAD: begin
        dec.valid = funct3 != 3'b011 && funct3[2:1] != 2'b11;
        dec.cls = riscv_isa_pkg::CLS_LOAD;
        dec.use_imm = 1'b1;
        dec.imm = imm_i;
      end
      riscv_isa_pkg::OPC_STORE: begin
        dec.valid = !funct3[2] && funct3[1:0] != 2'b11;
        dec.cls = riscv_isa_pkg::CLS_STORE;
        dec.use_imm = 1'b1;
        dec.rd = '0;
        dec.imm = imm_s;
      end
      riscv_isa_pkg::OPC_OP_IMM: begin
        dec.valid = (funct3 != 3'b001 && funct3 != 3'b101) || funct7 == 7'b0 ||
                    (funct3 == 3'b101 && alt);
        dec.use_imm = 1'b1;
        dec.alu_op = alu_sel(funct3, alt && funct3 == 3'b101);
        dec.imm = imm_i;
      end
      riscv_isa_pkg::OPC_OP: begin
        dec.valid = funct7 == 7'b0 || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
        dec.alu_op = alu_sel(funct3, alt);
      end
      // ecall and ebreak end in a trap
      riscv_isa_pkg::OPC_SYSTEM: dec.valid = 1'b0;
      default: dec.valid = 1'b0;
    endcase
  end

endmodule

//--- hdl/riscv_regfile.sv
`include "riscv_consts.svh"

module riscv_regfile (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`RISCV_REG_BITS-1:0] rs1_addr,
  input  logic [`RISCV_REG_BITS-1:0] rs2_addr,
  output logic [`RISCV_XLEN-1:0]     rs1_data,
  output logic [`RISCV_XLEN-1:0]     rs2_data,
  input  logic                       wr_en,
  input  logic [`RISCV_REG_BITS-1:0] wr_addr,
  input  logic [`RISCV_XLEN-1:0]     wr_data
);

  logic [`RISCV_XLEN-1:0] regs [`RISCV_REG_COUNT];

  // x0 is never written, reads are forced to zero
  always_ff @(posedge clk) begin
    if (!reset && wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- hdl/riscv_alu.sv
`include "riscv_consts.svh"

module riscv_alu (
  input  riscv_isa_pkg::alu_op_e     op,
  input  logic [`RISCV_XLEN-1:0]     a,
  input  logic [`RISCV_XLEN-1:0]     b,
  output logic [`RISCV_XLEN-1:0]     y,
  input  riscv_isa_pkg::branch_op_e  branch_op,
  output logic                       branch_taken
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt = b[4:0];
  assign lt_signed = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      riscv_isa_pkg::ALU_SUB:  y = a - b;
      riscv_isa_pkg::ALU_SLL:  y = a << shamt;
      riscv_isa_pkg::ALU_SLT:  y = {{(`RISCV_XLEN-1){1'b0}}, lt_signed};
      riscv_isa_pkg::ALU_SLTU: y = {{(`RISCV_XLEN-1){1'b0}}, lt_unsigned};
      riscv_isa_pkg::ALU_XOR:  y = a ^ b;
      riscv_isa_pkg::ALU_SRL:  y = a >> shamt;
      riscv_isa_pkg::ALU_SRA:  y = $signed(a) >>> shamt;
      riscv_isa_pkg::ALU_OR:   y = a | b;
      riscv_isa_pkg::ALU_AND:  y = a & b;
      default:                 y = a + b;
    endcase
  end

  always_comb begin
    case (branch_op)
      riscv_isa_pkg::BR_EQ:  branch_taken = a == b;
      riscv_isa_pkg::BR_NE:  branch_taken = a != b;
      riscv_isa_pkg::BR_LT:  branch_taken = lt_signed;
      riscv_isa_pkg::BR_GE:  branch_taken = !lt_signed;
      riscv_isa_pkg::BR_LTU: branch_taken = lt_unsigned;
      default:               branch_taken = !lt_unsigned;
    endcase
  end

endmodule

//--- hdl/riscv_lsu.sv
`include "riscv_consts.svh"

module riscv_lsu (
  input  logic                   clk,
  input  logic                   reset,
  riscv_lsu_if.responder         ctrl,
  output logic                   mem_valid,
  output logic                   mem_instr,
  input  logic                   mem_ready,
  output logic [`RISCV_XLEN-1:0] mem_addr,
  output logic [`RISCV_XLEN-1:0] mem_wdata,
  output logic [3:0]             mem_wstrb,
  input  logic [`RISCV_XLEN-1:0] mem_rdata
);

  riscv_isa_pkg::mem_size_e size_q;
  logic                     unsigned_q;
  logic [1:0]               offset_q;
  logic [3:0]               strobe;
  logic [`RISCV_XLEN-1:0]   wdata;
  logic [7:0]               byte_sel;
  logic [15:0]              half_sel;

  assign ctrl.misaligned =
    (ctrl.size == riscv_isa_pkg::MEM_HALF && ctrl.addr[0]) ||
    (ctrl.size == riscv_isa_pkg::MEM_WORD && ctrl.addr[1:0] != 2'b00);

  // replicate store data so every lane carries it, strobes pick the lanes
  always_comb begin
    case (ctrl.size)
      riscv_isa_pkg::MEM_BYTE: begin
        strobe = 4'b0001 << ctrl.addr[1:0];
        wdata = {4{ctrl.store_data[7:0]}};
      end
      riscv_isa_pkg::MEM_HALF: begin
        strobe = ctrl.addr[1] ? 4'b1100 : 4'b0011;
        wdata = {2{ctrl.store_data[15:0]}};
      end
      default: begin
        strobe = 4'b1111;
        wdata = ctrl.store_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_valid <= 1'b0;
      mem_wstrb <= 4'b0000;
    end else if (ctrl.req) begin
      mem_valid <= 1'b1;
      mem_wstrb <= (ctrl.kind == riscv_core_pkg::LSU_STORE) ? strobe : 4'b0000;
    end else if (ctrl.done) begin
      mem_valid <= 1'b0;
      mem_wstrb <= 4'b0000;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.req) begin
      mem_addr <= {ctrl.addr[`RISCV_XLEN-1:2], 2'b00};
      mem_instr <= ctrl.kind == riscv_core_pkg::LSU_FETCH;
      mem_wdata <= wdata;
      size_q <= ctrl.size;
      unsigned_q <= ctrl.unsigned_load;
      offset_q <= ctrl.addr[1:0];
    end
  end

  assign ctrl.done = mem_valid && mem_ready;

  // load lane select and extension
  assign byte_sel = mem_rdata[8*offset_q +: 8];
  assign half_sel = offset_q[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    case (size_q)
      riscv_isa_pkg::MEM_BYTE:
        ctrl.rdata = {{(`RISCV_XLEN-8){byte_sel[7] & ~unsigned_q}}, byte_sel};
      riscv_isa_pkg::MEM_HALF:
        ctrl.rdata = {{(`RISCV_XLEN-16){half_sel[15] & ~unsigned_q}}, half_sel};
      default:
        ctrl.rdata = mem_rdata;
    endcase
  end

endmodule

//--- hdl/riscv_control.sv
`include "riscv_consts.svh"

module riscv_control (
  input  logic                       clk,
  input  logic                       reset,
  riscv_lsu_if.requester             lsu,
  output logic [`RISCV_XLEN-1:0]     instr,
  input  riscv_isa_pkg::decoded_t    dec,
  input  logic [`RISCV_XLEN-1:0]     rs1_data,
  input  logic [`RISCV_XLEN-1:0]     rs2_data,
  output logic                       wr_en,
  output logic [`RISCV_REG_BITS-1:0] wr_addr,
  output logic [`RISCV_XLEN-1:0]     wr_data,
  output logic [`RISCV_XLEN-1:0]     alu_a,
  output logic [`RISCV_XLEN-1:0]     alu_b,
  input  logic [`RISCV_XLEN-1:0]     alu_y,
  input  logic                       branch_taken,
  output logic                       trap
);

  riscv_core_pkg::ctrl_state_e state;
  logic [`RISCV_XLEN-1:0] pc, pc_seq, target, result;
  logic fetch_busy;
  logic is_mem;

  assign pc_seq = pc + `RISCV_INSTR_STEP;
  assign is_mem = dec.cls == riscv_isa_pkg::CLS_LOAD || dec.cls == riscv_isa_pkg::CLS_STORE;
  // jalr drops bit 0, branch and jal are pc relative
  assign target = (dec.cls == riscv_isa_pkg::CLS_JALR) ? {alu_y[`RISCV_XLEN-1:1], 1'b0} :
                                                         pc + dec.imm;

  assign alu_a = (dec.cls == riscv_isa_pkg::CLS_AUIPC) ? pc : rs1_data;
  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  always_comb begin
    lsu.kind = riscv_core_pkg::LSU_FETCH;
    lsu.size = riscv_isa_pkg::MEM_WORD;
    lsu.addr = pc;
    if (state == riscv_core_pkg::ST_EXECUTE && is_mem) begin
      lsu.kind = (dec.cls == riscv_isa_pkg::CLS_STORE) ? riscv_core_pkg::LSU_STORE :
                                                         riscv_core_pkg::LSU_LOAD;
      lsu.size = dec.size;
      lsu.addr = alu_y;
    end
  end

  assign lsu.unsigned_load = dec.unsigned_load;
  assign lsu.store_data = rs2_data;
  assign lsu.req = (state == riscv_core_pkg::ST_FETCH) ? !fetch_busy :
                   (state == riscv_core_pkg::ST_EXECUTE && is_mem && !lsu.misaligned);

  assign wr_en = state == riscv_core_pkg::ST_WRITEBACK;
  assign wr_addr = dec.rd;
  assign wr_data = result;
  assign trap = state == riscv_core_pkg::ST_TRAP;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= riscv_core_pkg::ST_FETCH;
      pc <= `RISCV_RESET_PC;
      fetch_busy <= 1'b0;
    end else begin
      case (state)
        riscv_core_pkg::ST_FETCH: begin
          if (lsu.req) fetch_busy <= 1'b1;
          if (lsu.done) begin
            fetch_busy <= 1'b0;
            state <= riscv_core_pkg::ST_DECODE;
          end
        end
        riscv_core_pkg::ST_DECODE:
          state <= dec.valid ? riscv_core_pkg::ST_EXECUTE : riscv_core_pkg::ST_TRAP;
        riscv_core_pkg::ST_EXECUTE: begin
          pc <= pc_seq;
          state <= riscv_core_pkg::ST_WRITEBACK;
          if (dec.cls == riscv_isa_pkg::CLS_JAL || dec.cls == riscv_isa_pkg::CLS_JALR) begin
            pc <= target;
            if (target[0]) state <= riscv_core_pkg::ST_TRAP;
          end else if (dec.cls == riscv_isa_pkg::CLS_BRANCH) begin
            if (branch_taken) pc <= target;
            state <= (branch_taken && target[0]) ? riscv_core_pkg::ST_TRAP :
                                                   riscv_core_pkg::ST_FETCH;
          end else if (is_mem) begin
            state <= lsu.misaligned ? riscv_core_pkg::ST_TRAP : riscv_core_pkg::ST_MEM_WAIT;
          end
        end
        riscv_core_pkg::ST_MEM_WAIT: begin
          if (lsu.done) begin
            state <= (dec.cls == riscv_isa_pkg::CLS_LOAD) ? riscv_core_pkg::ST_WRITEBACK :
                                                            riscv_core_pkg::ST_FETCH;
          end
        end
        riscv_core_pkg::ST_WRITEBACK: state <= riscv_core_pkg::ST_FETCH;
        default: state <= riscv_core_pkg::ST_TRAP;
      endcase
    end
  end

  // instruction and result registers
  always_ff @(posedge clk) begin
    if (state == riscv_core_pkg::ST_FETCH && lsu.done) instr <= lsu.rdata;
    if (state == riscv_core_pkg::ST_EXECUTE) begin
      if (dec.cls == riscv_isa_pkg::CLS_JAL || dec.cls == riscv_isa_pkg::CLS_JALR) begin
        result <= pc_seq;
      end else begin
        result <= alu_y;
      end
    end
    if (state == riscv_core_pkg::ST_MEM_WAIT && lsu.done) result <= lsu.rdata;
  end

endmodule

//--- hdl/riscv_core.sv
`include "riscv_consts.svh"

module riscv_core (
  input  logic                   clk,
  input  logic                   reset,
  output logic                   mem_valid,
  output logic                   mem_instr,
  input  logic                   mem_ready,
  output logic [`RISCV_XLEN-1:0] mem_addr,
  output logic [`RISCV_XLEN-1:0] mem_wdata,
  output logic [3:0]             mem_wstrb,
  input  logic [`RISCV_XLEN-1:0] mem_rdata,
  output logic                   trap
);

  riscv_isa_pkg::decoded_t     dec;
  logic [`RISCV_XLEN-1:0]      instr, rs1_data, rs2_data, wr_data;
  logic [`RISCV_XLEN-1:0]      alu_a, alu_b, alu_y;
  logic [`RISCV_REG_BITS-1:0]  wr_addr;
  logic                        wr_en, branch_taken;

  riscv_lsu_if lsu_bus ();

  riscv_control control (
    .clk, .reset, .lsu(lsu_bus), .instr, .dec, .rs1_data, .rs2_data,
    .wr_en, .wr_addr, .wr_data, .alu_a, .alu_b, .alu_y, .branch_taken, .trap
  );

  riscv_decoder decoder (.instr, .dec);

  riscv_regfile regfile (
    .clk, .reset, .rs1_addr(dec.rs1), .rs2_addr(dec.rs2), .rs1_data, .rs2_data,
    .wr_en, .wr_addr, .wr_data
  );

  riscv_alu alu (
    .op(dec.alu_op), .a(alu_a), .b(alu_b), .y(alu_y),
    .branch_op(dec.branch_op), .branch_taken
  );

  riscv_lsu lsu (
    .clk, .reset, .ctrl(lsu_bus), .mem_valid, .mem_instr, .mem_ready,
    .mem_addr, .mem_wdata, .mem_wstrb, .mem_rdata
  );

endmodule

//--- test/riscv_checker.sv
module riscv_checker (
  input logic        clk,
  input logic        reset,
  input logic        mem_valid,
  input logic        mem_instr,
  input logic        mem_ready,
  input logic [31:0] mem_addr,
  input logic [31:0] mem_wdata,
  input logic [3:0]  mem_wstrb,
  input logic        trap
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] img [1024];
  logic [31:0] regs [32];
  logic [31:0] pc, pend_addr, pend_data;
  logic [31:0] last_addr, last_wdata;
  logic [3:0]  last_wstrb;
  logic [2:0]  pend_f3;
  logic [4:0]  pend_rd;
  logic [1:0]  pend_kind;
  logic        trap_expected, trap_seen, stalled, last_instr;
  int          errors = 0;
  int          checks = 0;
  int          fetches = 0;

  task automatic load_word(int idx, logic [31:0] w);
    img[idx] = w;
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic plain_error(string msg);
    $display("%s at %0t", msg, $time);
    errors++;
  endtask

  function automatic logic [31:0] alu(logic [2:0] f3, logic alt, logic [31:0] a, logic [31:0] b);
    case (f3)
      0: return alt ? a - b : a + b;
      1: return a << b[4:0];
      2: return {31'b0, $signed(a) < $signed(b)};
      3: return {31'b0, a < b};
      4: return a ^ b;
      5: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      0: return a == b;
      1: return a != b;
      4: return $signed(a) < $signed(b);
      5: return $signed(a) >= $signed(b);
      6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic misaligned(logic [1:0] sz, logic [31:0] addr);
    return (sz == 1 && addr[0]) || (sz == 2 && addr[1:0] != 0);
  endfunction

  task automatic execute(logic [31:0] w);
    logic [31:0] a, b, imm_i, imm_s, res, t, ea;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [1:0]  kind;
    logic        bad;
    a = regs[w[19:15]];
    b = regs[w[24:20]];
    f3 = w[14:12];
    f7 = w[31:25];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    res = 0;
    t = pc + 4;
    bad = 0;
    kind = 0;
    ea = 0;
    case (w[6:0])
      7'h37: res = {w[31:12], 12'b0};
      7'h17: res = pc + {w[31:12], 12'b0};
      7'h6f: begin
        res = pc + 4;
        t = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        bad = t[0];
      end
      7'h67: begin
        res = pc + 4;
        t = (a + imm_i) & ~32'd1;
        bad = f3 != 0;
      end
      7'h63: begin
        if (taken(f3, a, b)) t = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        bad = f3 == 2 || f3 == 3 || t[0];
      end
      7'h03: begin
        ea = a + imm_i;
        kind = 1;
        bad = f3 == 3 || f3 > 5 || misaligned(f3[1:0], ea);
      end
      7'h23: begin
        ea = a + imm_s;
        kind = 2;
        bad = f3 > 2 || misaligned(f3[1:0], ea);
      end
      7'h13: begin
        bad = (f3 == 1 && f7 != 0) || (f3 == 5 && f7 != 0 && f7 != 7'h20);
        res = alu(f3, f3 == 5 && f7 == 7'h20, a, imm_i);
      end
      7'h33: begin
        bad = f7 != 0 && !(f7 == 7'h20 && (f3 == 0 || f3 == 5));
        res = alu(f3, f7 == 7'h20, a, b);
      end
      default: bad = 1;
    endcase
    if (bad) begin
      trap_expected = 1;
    end else begin
      // branches and stores have no destination register
      if (w[6:0] != 7'h63 && kind == 0 && w[11:7] != 0) regs[w[11:7]] = res;
      pc = t;
      pend_kind = kind;
      pend_addr = ea;
      pend_f3 = f3;
      pend_rd = w[11:7];
      pend_data = b;
    end
  endtask

  task automatic handle_transfer();
    logic [31:0] word, val, lanes, mask;
    logic [3:0]  strb;
    logic [1:0]  off;
    off = pend_addr[1:0];
    if (trap_expected) begin
      plain_error("bus transfer after a trapping instruction");
    end else if (pend_kind == 0) begin
      check_value("mem_instr", mem_instr, 1);
      check_value("mem_wstrb", mem_wstrb, 0);
      check_value("mem_addr", mem_addr, pc);
      fetches++;
      execute(img[pc[11:2]]);
    end else if (pend_kind == 1) begin
      check_value("mem_instr", mem_instr, 0);
      check_value("mem_wstrb", mem_wstrb, 0);
      check_value("mem_addr", mem_addr, {pend_addr[31:2], 2'b00});
      word = img[pend_addr[11:2]];
      case (pend_f3[1:0])
        0: val = {{24{word[8*off+7] & ~pend_f3[2]}}, word[8*off +: 8]};
        1: val = {{16{word[16*off[1]+15] & ~pend_f3[2]}}, word[16*off[1] +: 16]};
        default: val = word;
      endcase
      if (pend_rd != 0) regs[pend_rd] = val;
      pend_kind = 0;
    end else begin
      check_value("mem_instr", mem_instr, 0);
      check_value("mem_addr", mem_addr, {pend_addr[31:2], 2'b00});
      case (pend_f3[1:0])
        0: begin
          strb = 4'b0001 << off;
          lanes = {4{pend_data[7:0]}};
        end
        1: begin
          strb = off[1] ? 4'b1100 : 4'b0011;
          lanes = {2{pend_data[15:0]}};
        end
        default: begin
          strb = 4'b1111;
          lanes = pend_data;
        end
      endcase
      check_value("mem_wstrb", mem_wstrb, strb);
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      check_value("mem_wdata", mem_wdata & mask, lanes & mask);
      img[pend_addr[11:2]] = (img[pend_addr[11:2]] & ~mask) | (lanes & mask);
      pend_kind = 0;
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      pc = 32'h0;
      pend_kind = 0;
      trap_expected = 0;
      trap_seen = 0;
      stalled = 0;
      fetches = 0;
      regs = '{default: 32'h0};
    end else begin
      // a stalled request must hold still until mem_ready
      if (stalled) begin
        if (!mem_valid) plain_error("mem_valid dropped before mem_ready");
        check_value("mem_addr", mem_addr, last_addr);
        check_value("mem_wdata", mem_wdata, last_wdata);
        check_value("mem_wstrb", mem_wstrb, last_wstrb);
        check_value("mem_instr", mem_instr, last_instr);
      end
      if (trap && !trap_expected) plain_error("trap raised with no trapping instruction");
      if (trap_seen && !trap) plain_error("trap fell before reset");
      if (trap_seen && mem_valid) plain_error("mem_valid high after trap");
      if (trap) trap_seen = 1;
      if (mem_valid && mem_ready) handle_transfer();
      stalled = mem_valid && !mem_ready;
      last_addr = mem_addr;
      last_wdata = mem_wdata;
      last_wstrb = mem_wstrb;
      last_instr = mem_instr;
    end
  end

endmodule

//--- test/riscv_tb.sv
module riscv_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PROG_WORDS = 200;
  localparam int MEM_WORDS = 1024;
  // two passes over the program
  localparam int TIMEOUT_NS = 2 * PROG_WORDS * 40 * 8;

  logic        clk, reset, mem_valid, mem_instr, mem_ready, trap;
  logic [31:0] mem_addr, mem_wdata, mem_rdata;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] rng;
  int          pos;
  int          tb_errors;
  int          bad_store_idx;
  int          illegal_idx;

  riscv_core uut (
    .clk, .reset, .mem_valid, .mem_instr, .mem_ready, .mem_addr,
    .mem_wdata, .mem_wstrb, .mem_rdata, .trap
  );

  riscv_checker chk (
    .clk, .reset, .mem_valid, .mem_instr, .mem_ready, .mem_addr,
    .mem_wdata, .mem_wstrb, .trap
  );

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [4:0] pick_reg();
    return 5'(next_rand() % 31 + 1);
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic put_word(logic [31:0] w);
    mem[pos] = w;
    pos++;
  endtask

  task automatic put_filler();
    put_word(enc_i(12'(next_rand()), pick_reg(), 3'b000, pick_reg(), 7'b0010011));
  endtask

  task automatic build_program();
    logic [2:0]  f3, sz;
    logic [6:0]  f7;
    logic [4:0]  ra, rd;
    logic [11:0] imm;
    pos = 0;
    // every register gets a known value first
    for (int r = 1; r < 32; r++) put_word(enc_i(12'(next_rand()), 5'd0, 3'b000, 5'(r), 7'h13));
    while (pos < PROG_WORDS - 10) begin
      f3 = 3'(next_rand());
      case (next_rand() % 8)
        0, 1: begin
          f7 = ((f3 == 0 || f3 == 5) && next_rand() % 2) ? 7'h20 : 7'h00;
          put_word({f7, pick_reg(), pick_reg(), f3, pick_reg(), 7'h33});
        end
        2: begin
          imm = 12'(next_rand());
          if (f3 == 1) imm = {7'h00, imm[4:0]};
          if (f3 == 5) imm = {1'b0, imm[10], 5'h00, imm[4:0]};
          put_word(enc_i(imm, pick_reg(), f3, pick_reg(), 7'h13));
        end
        3: put_word({20'(next_rand()), pick_reg(), next_rand() % 2 ? 7'h37 : 7'h17});
        4: begin
          f3 = 3'(next_rand() % 6);
          if (f3 > 1) f3 = f3 + 3'd2;
          put_word(enc_b(13'd12, pick_reg(), pick_reg(), f3));
          put_filler();
          put_filler();
        end
        5: begin
          put_word(enc_j(21'd8, pick_reg()));
          put_filler();
        end
        6: begin
          // jalr target has bit 0 set, the core clears it
          ra = pick_reg();
          put_word({20'h0, ra, 7'h17});
          put_word(enc_i(12'd13, ra, 3'b000, pick_reg(), 7'h67));
          put_filler();
        end
        default: begin
          ra = pick_reg();
          rd = pick_reg();
          if (rd == ra) rd = (ra == 5'd31) ? 5'd1 : ra + 5'd1;
          put_word({20'h1, ra, 7'h37});
          put_word(enc_i(12'(-(next_rand() % 512 + 1) * 4), ra, 3'b000, ra, 7'h13));
          sz = 3'(next_rand() % 3);
          imm = (sz == 0) ? 12'(next_rand() % 4) : (sz == 1) ? 12'(next_rand() % 2 * 2) : 12'd0;
          if (sz != 2 && next_rand() % 2) sz = sz + 3'd4;
          put_word(enc_i(imm, ra, sz, rd, 7'h03));
          sz = 3'(next_rand() % 3);
          imm = (sz == 0) ? 12'(next_rand() % 4) : (sz == 1) ? 12'(next_rand() % 2 * 2) : 12'd0;
          put_word(enc_s(imm, rd, ra, sz));
          put_word(enc_s(12'd0, pick_reg(), ra, 3'b010));
        end
      endcase
    end
    // misaligned halfword store, then an illegal word
    put_word({20'h1, 5'd5, 7'h37});
    put_word(enc_i(12'h800, 5'd5, 3'b000, 5'd5, 7'h13));
    bad_store_idx = pos;
    put_word(enc_s(12'd1, 5'd1, 5'd5, 3'b001));
    illegal_idx = pos;
    put_word(32'h0000_0000);
    // opcode field zero keeps the rest of the code half illegal
    while (pos < MEM_WORDS / 2) put_word({25'(pos), 7'h00});
    while (pos < MEM_WORDS) put_word(next_rand());
  endtask

  task automatic run_to_trap(logic [31:0] trap_pc);
    reset = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    wait (trap === 1'b1);
    repeat (20) @(negedge clk);
    if (!chk.trap_expected) begin
      $display("trap came before the model reached a trapping instruction");
      tb_errors++;
    end
    if (chk.pc !== trap_pc) begin
      $display("trap taken at model pc %h instead of %h", chk.pc, trap_pc);
      tb_errors++;
    end
    if (chk.fetches < PROG_WORDS / 2) begin
      $display("too few fetches before trap: %0d", chk.fetches);
      tb_errors++;
    end
  endtask

  always #4 clk = ~clk;

  always @(negedge clk) begin
    mem_ready = next_rand() % 4 != 0;
    if (mem_valid) mem_rdata = mem[mem_addr[11:2]];
  end

  always @(posedge clk) begin
    if (!reset && mem_valid && mem_ready) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_wstrb[b]) mem[mem_addr[11:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the core never raised trap");
    $display("checks: %0d  errors: %0d", chk.checks, chk.errors + tb_errors + 1);
    $display("Errors found");
    $finish;
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    tb_errors = 0;
    rng = 32'h301b;
    build_program();
    for (int i = 0; i < MEM_WORDS; i++) chk.load_word(i, mem[i]);
    run_to_trap(32'(bad_store_idx * 4));
    // rerun with the misaligned store turned into a nop so the illegal word is reached
    mem[bad_store_idx] = 32'h0000_0013;
    chk.load_word(bad_store_idx, 32'h0000_0013);
    run_to_trap(32'(illegal_idx * 4));
    $display("checks: %0d  errors: %0d", chk.checks, chk.errors + tb_errors);
    if (chk.errors + tb_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+hdl
hdl/riscv_isa_pkg.sv
hdl/riscv_core_pkg.sv
hdl/riscv_lsu_if.sv
hdl/riscv_decoder.sv
hdl/riscv_regfile.sv
hdl/riscv_alu.sv
hdl/riscv_lsu.sv
hdl/riscv_control.sv
hdl/riscv_core.sv
test/riscv_checker.sv
test/riscv_tb.sv

//--- Bender.yml
package:
  name: riscv_core

sources:
  - target: rtl
    include_dirs:
      - hdl
    files:
      - hdl/riscv_isa_pkg.sv
      - hdl/riscv_core_pkg.sv
      - hdl/riscv_lsu_if.sv
      - hdl/riscv_decoder.sv
      - hdl/riscv_regfile.sv
      - hdl/riscv_alu.sv
      - hdl/riscv_lsu.sv
      - hdl/riscv_control.sv
      - hdl/riscv_core.sv
  - target: test
    files:
      - test/riscv_checker.sv
      - test/riscv_tb.sv
